// File: reb_tracker_cases.txt
# alloc commit miss rt rt2 miss_id lookup_reg | live_target live_target2 full empty hit id
# All columns hex, each line is one operation followed by the outputs after its edge
0 0 0 00 00 0 05 00000000 00000000 0 1 0 0
1 0 0 01 02 0 01 00000002 00000004 0 0 1 0
1 0 0 03 00 0 02 0000000a 00000004 0 0 1 0
1 0 0 01 04 0 01 0000000a 00000014 0 0 1 2
1 0 0 05 06 0 06 0000002a 00000054 0 0 1 3
1 0 0 07 08 0 08 000000aa 00000154 0 0 1 4
1 0 0 09 00 0 04 000002aa 00000154 0 0 1 2
1 0 0 00 00 0 00 000002aa 00000154 0 0 0 0
1 0 0 03 01 0 03 000002aa 00000156 1 0 1 7
0 0 0 00 00 0 01 000002aa 00000156 1 0 1 7
1 0 0 0a 0b 0 0a 000002aa 00000156 1 0 0 0
0 1 0 00 00 0 02 000002aa 00000152 0 0 0 0
0 1 0 00 00 0 03 000002aa 00000152 0 0 1 7
0 1 0 00 00 0 04 000002a8 00000142 0 0 0 0
0 0 0 00 00 0 01 000002a8 00000142 0 0 1 7
1 0 0 05 02 0 05 000002a8 00000146 0 0 1 0
1 0 0 07 09 0 09 000002a8 00000346 0 0 1 1
0 0 1 00 00 4 07 000000a0 00000140 0 0 1 4
0 0 0 00 00 0 05 000000a0 00000140 0 0 1 3
0 0 0 00 00 0 09 000000a0 00000140 0 0 0 0
1 0 1 0a 0b 4 0a 000000a0 00000140 0 0 0 0
1 0 0 06 05 0 06 000000e0 00000160 0 0 1 5
1 0 0 06 00 0 06 000000e0 00000160 0 0 1 6
0 0 1 00 00 5 06 000000e0 00000160 0 0 1 5
0 1 0 00 00 0 05 000000c0 00000120 0 0 1 5
0 1 0 00 00 0 07 00000040 00000020 0 0 0 0
0 1 0 00 00 0 06 00000000 00000000 0 1 0 0
0 1 0 00 00 0 06 00000000 00000000 0 1 0 0
1 0 0 01 01 0 01 00000002 00000002 0 0 1 6
1 0 0 02 00 0 02 00000006 00000002 0 0 1 7
1 0 0 03 00 0 03 0000000e 00000002 0 0 1 0
1 0 0 04 00 0 04 0000001e 00000002 0 0 1 1
1 0 0 01 00 0 01 0000001e 00000002 0 0 1 2
1 0 0 00 04 0 04 0000001e 00000012 0 0 1 3
1 0 0 05 00 0 05 0000003e 00000012 0 0 1 4
1 0 0 1f 1f 0 1f 8000003e 80000012 1 0 1 5
0 0 1 00 00 1 04 0000001e 00000002 0 0 1 1
0 0 0 00 00 0 01 0000001e 00000002 0 0 1 6
0 1 0 00 00 0 01 0000001c 00000000 0 0 0 0
0 1 0 00 00 0 02 00000018 00000000 0 0 0 0
1 0 0 03 02 0 03 00000018 00000004 0 0 1 2
0 1 0 00 00 0 03 00000018 00000004 0 0 1 2
0 1 0 00 00 0 04 00000008 00000004 0 0 0 0
1 1 0 06 07 0 03 00000040 00000080 0 0 0 0
0 1 0 00 00 0 06 00000000 00000000 0 1 0 0

// File: reb_tracker.f
reb_pkg.sv
reb_queue.sv
reb_live_target.sv
reg_writer_map.sv
reb_tracker_top.sv
tb_reb_tracker.sv

// File: run_sim.sh
#!/bin/sh
# Builds the tracker testbench with Verilator, runs it from the project root
# and decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_reb_tracker \
	-f reb_tracker.f \
	--Mdir obj_dir -o sim_reb_tracker > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_reb_tracker > sim.log 2>&1
cat sim.log

grep -q "^Everything OK$" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

// File: tb_reb_tracker.sv
/*
 * Testbench for the reorder-buffer write tracker.
 * Replays the operations in reb_tracker_cases.txt, checks the DUT and a reference
 * model against the expected columns, then runs a seeded random phase against the model.
 */

`timescale 1ns/100ps

module tb_reb_tracker;

	// ================================================
	// Types, constants and signals
	// ================================================

	// One line of the data file with the operation first and the expected outputs last
	typedef struct packed {
		logic        alloc;
		logic        commit;
		logic        miss;
		logic [4:0]  rt;
		logic [4:0]  rt2;
		logic [2:0]  miss_id;
		logic [4:0]  lookup_reg;
		logic [31:0] lt;
		logic [31:0] lt2;
		logic        full;
		logic        empty;
		logic        hit;
		logic [2:0]  id;
	} case_t;

	// Observable outputs of the tracker
	typedef struct packed {
		logic [31:0] lt;
		logic [31:0] lt2;
		logic        full;
		logic        empty;
		logic        hit;
		logic [2:0]  id;
	} obs_t;

	localparam int RAND_STEPS = 200;
	// Every step takes one cycle for the strobe and one for the idle check
	localparam int CYC_PER_STEP = 2;

	logic                clk;
	logic                arst_n;
	logic                alloc;
	reb_pkg::alloc_req_t alloc_req;
	logic                commit;
	logic                miss;
	reb_pkg::reb_id_t    miss_id;
	reb_pkg::reg_num_t   lookup_reg;
	reb_pkg::reg_mask_t  live_target;
	reb_pkg::reg_mask_t  live_target2;
	logic                full;
	logic                empty;
	logic                lookup_hit;
	reb_pkg::reb_id_t    lookup_id;

	case_t cases[$];
	bit    cases_loaded;
	int    error_count;
	int    check_count;
	int    seed;

	// Reference model state indexed like the buffer slots
	logic       m_valid[8];
	logic [4:0] m_rt[8];
	logic [4:0] m_rt2[8];
	int         m_head;
	int         m_tail;
	int         m_count;

	reb_tracker_top dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.alloc        (alloc),
		.alloc_req    (alloc_req),
		.commit       (commit),
		.miss         (miss),
		.miss_id      (miss_id),
		.lookup_reg   (lookup_reg),
		.live_target  (live_target),
		.live_target2 (live_target2),
		.full         (full),
		.empty        (empty),
		.lookup_hit   (lookup_hit),
		.lookup_id    (lookup_id)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog sized from the number of steps once the data file is read
	initial begin
		wait (cases_loaded);
		#((cases.size() + RAND_STEPS + 20) * CYC_PER_STEP * 10);
		$display("Timeout: the run did not reach its end in the expected time");
		$display("Something failed");
		$finish;
	end

	// ================================================
	// Checking
	// ================================================

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic compare_obs(input string who, input obs_t got, input obs_t exp);
		check_value({who, " live_target"}, got.lt, exp.lt);
		check_value({who, " live_target2"}, got.lt2, exp.lt2);
		check_value({who, " full"}, 32'(got.full), 32'(exp.full));
		check_value({who, " empty"}, 32'(got.empty), 32'(exp.empty));
		check_value({who, " lookup_hit"}, 32'(got.hit), 32'(exp.hit));
		check_value({who, " lookup_id"}, 32'(got.id), 32'(exp.id));
	endtask

	// ================================================
	// Reference model
	// ================================================

	// A miss wins the cycle
	// Otherwise a full buffer refuses alloc and an empty one refuses commit,
	// both judged on the occupancy before the edge
	task automatic model_step(input logic a, input logic c, input logic m,
			input logic [4:0] rt, input logic [4:0] rt2, input logic [2:0] mid);
		int mid_age;
		int age;
		bit do_commit;
		bit do_alloc;
		if (m) begin
			mid_age = (int'(mid) - m_head + 8) % 8;
			for (int i = 0; i < 8; i++) begin
				age = (i - m_head + 8) % 8;
				if (age > mid_age) begin
					m_valid[i] = 1'b0;
				end
			end
			m_tail  = (int'(mid) + 1) % 8;
			m_count = mid_age + 1;
		end else begin
			do_commit = c && m_count > 0;
			do_alloc  = a && m_count < 8;
			if (do_commit) begin
				m_valid[m_head] = 1'b0;
				m_head          = (m_head + 1) % 8;
				m_count--;
			end
			if (do_alloc) begin
				m_valid[m_tail] = 1'b1;
				m_rt[m_tail]    = rt;
				m_rt2[m_tail]   = rt2;
				m_tail          = (m_tail + 1) % 8;
				m_count++;
			end
		end
	endtask

	// Live registers of all surviving entries and the newest writer of lk
	function automatic obs_t model_outputs(input logic [4:0] lk);
		obs_t o;
		int   idx;
		o = '0;
		for (int age = 0; age < m_count; age++) begin
			idx = (m_head + age) % 8;
			if (m_valid[idx]) begin
				o.lt  = o.lt | ((32'd1 << m_rt[idx]) & ~32'd1);
				o.lt2 = o.lt2 | ((32'd1 << m_rt2[idx]) & ~32'd1);
				if (lk != 5'd0 && (m_rt[idx] == lk || m_rt2[idx] == lk)) begin
					o.hit = 1'b1;
					o.id  = 3'(idx);
				end
			end
		end
		o.full  = (m_count == 8);
		o.empty = (m_count == 0);
		return o;
	endfunction

	// ================================================
	// Stimulus
	// ================================================

	// Strobe for one cycle and then hold idle and sample in the middle of the next one
	task automatic run_step(input logic a, input logic c, input logic m,
			input logic [4:0] rt, input logic [4:0] rt2, input logic [2:0] mid,
			input logic [4:0] lk, output obs_t got);
		@(posedge clk);
		#1;
		alloc      = a;
		commit     = c;
		miss       = m;
		alloc_req  = {rt, rt2};
		miss_id    = mid;
		lookup_reg = lk;
		@(posedge clk);
		#1;
		alloc  = 1'b0;
		commit = 1'b0;
		miss   = 1'b0;
		model_step(a, c, m, rt, rt2, mid);
		@(negedge clk);
		got = {live_target, live_target2, full, empty, lookup_hit, lookup_id};
	endtask

	task automatic load_cases(output bit opened);
		int    fd;
		int    n;
		string line;
		int    v[13];
		case_t cs;
		fd     = $fopen("reb_tracker_cases.txt", "r");
		opened = (fd != 0);
		if (opened) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1],
						v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], v[12]);
					if (n == 13) begin
						cs = {v[0][0], v[1][0], v[2][0], v[3][4:0], v[4][4:0], v[5][2:0],
							v[6][4:0], v[7], v[8], v[9][0], v[10][0], v[11][0], v[12][2:0]};
						cases.push_back(cs);
					end else begin
						error_count++;
						$display("A line of the case file does not hold 13 columns");
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		obs_t  got;
		obs_t  exp;
		case_t cs;
		logic  ra;
		logic  rc;
		logic  rm;
		logic [2:0] rmid;
		int    sel;
		bit    opened;
		arst_n     = 1'b0;
		alloc      = 1'b0;
		alloc_req  = '0;
		commit     = 1'b0;
		miss       = 1'b0;
		miss_id    = '0;
		lookup_reg = '0;
		error_count = 0;
		check_count = 0;
		seed        = 32'hc52f_aed4;
		m_head  = 0;
		m_tail  = 0;
		m_count = 0;
		for (int i = 0; i < 8; i++) begin
			m_valid[i] = 1'b0;
			m_rt[i]    = '0;
			m_rt2[i]   = '0;
		end
		load_cases(opened);
		if (!opened) begin
			$display("Could not open the case file reb_tracker_cases.txt");
			$display("Something failed");
			$finish;
		end else begin
			if (cases.size() == 0) begin
				error_count++;
				$display("The case file holds no usable cases");
			end
			cases_loaded = 1'b1;
			repeat (5) @(posedge clk);
			#1;
			arst_n = 1'b1;

			// The DUT and the model both answer to the file in the directed cases
			foreach (cases[i]) begin
				cs = cases[i];
				run_step(cs.alloc, cs.commit, cs.miss, cs.rt, cs.rt2, cs.miss_id,
					cs.lookup_reg, got);
				exp = {cs.lt, cs.lt2, cs.full, cs.empty, cs.hit, cs.id};
				compare_obs("dut", got, exp);
				compare_obs("model", model_outputs(cs.lookup_reg), exp);
			end

			// Misses in the random phase only ever name a live entry
			for (int s = 0; s < RAND_STEPS; s++) begin
				sel  = {$random(seed)} % 8;
				ra   = (sel < 4) || (sel == 7) || (sel == 6 && $random(seed) % 2 == 0);
				rc   = (sel == 4) || (sel == 5) || (sel == 7);
				rm   = (sel == 6) && (m_count > 0);
				rmid = (m_count > 0) ? 3'((m_head + {$random(seed)} % m_count) % 8) : 3'd0;
				run_step(ra, rc, rm, 5'({$random(seed)} % 8), 5'({$random(seed)} % 8), rmid,
					5'({$random(seed)} % 8), got);
				compare_obs("dut", got, model_outputs(lookup_reg));
			end

			$display("Checks run %0d, errors %0d", check_count, error_count);
			if (error_count == 0) begin
				$display("Everything OK");
			end else begin
				$display("Something failed");
			end
			$finish;
		end
	end

endmodule

// File: reb_tracker_top.sv
/*
 * Top level of the reorder-buffer write tracker.
 * Connects the entry queue, the live-target logic and the writer map.
 */

`timescale 1ns/100ps

module reb_tracker_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 alloc,
	input  reb_pkg::alloc_req_t  alloc_req,
	input  logic                 commit,
	input  logic                 miss,
	input  reb_pkg::reb_id_t     miss_id,
	input  reb_pkg::reg_num_t    lookup_reg,
	output reb_pkg::reg_mask_t   live_target,
	output reb_pkg::reg_mask_t   live_target2,
	output logic                 full,
	output logic                 empty,
	output logic                 lookup_hit,
	output reb_pkg::reb_id_t     lookup_id
);

	// Queue state as seen by the live-target logic
	reb_pkg::reb_entry_t [reb_pkg::REB_ENTRIES-1:0] reb;
	reb_pkg::reb_age_t   [reb_pkg::REB_ENTRIES-1:0] ages;
	logic                [reb_pkg::REB_ENTRIES-1:0] stomp;

	// Accepted allocate and commit events for the writer map
	reb_pkg::reb_id_t alloc_id;
	logic             alloc_fire;
	reb_pkg::reb_id_t commit_id;
	logic             commit_fire;

	// Per-entry newest-writer masks used to rebuild the map on a miss
	reb_pkg::reg_mask_t [reb_pkg::REB_ENTRIES-1:0] latest_id;
	reb_pkg::reg_mask_t [reb_pkg::REB_ENTRIES-1:0] latest_id2;

	reb_queue u_queue (
		.clk         (clk),
		.arst_n      (arst_n),
		.alloc       (alloc),
		.alloc_req   (alloc_req),
		.commit      (commit),
		.miss        (miss),
		.miss_id     (miss_id),
		.reb         (reb),
		.ages        (ages),
		.stomp       (stomp),
		.alloc_id    (alloc_id),
		.alloc_fire  (alloc_fire),
		.commit_id   (commit_id),
		.commit_fire (commit_fire),
		.full        (full),
		.empty       (empty)
	);

	reb_live_target u_live (
		.reb          (reb),
		.stomp        (stomp),
		.ages         (ages),
		.miss_id      (miss_id),
		.live_target  (live_target),
		.live_target2 (live_target2),
		.latest_id    (latest_id),
		.latest_id2   (latest_id2)
	);

	reg_writer_map u_map (
		.clk         (clk),
		.arst_n      (arst_n),
		.alloc_fire  (alloc_fire),
		.alloc_id    (alloc_id),
		.alloc_req   (alloc_req),
		.commit_fire (commit_fire),
		.commit_id   (commit_id),
		.miss        (miss),
		.latest_id   (latest_id),
		.latest_id2  (latest_id2),
		.lookup_reg  (lookup_reg),
		.lookup_hit  (lookup_hit),
		.lookup_id   (lookup_id)
	);

endmodule

// File: reg_writer_map.sv
/*
 * Register-to-writer map for the reorder buffer.
 * Keeps the newest in-flight writer of each register. Allocate and commit
 * update it in place, a branch miss rebuilds it from the latest-writer masks.
 */

`timescale 1ns/100ps

module reg_writer_map (
	input  logic                                              clk,
	input  logic                                              arst_n,
	input  logic                                              alloc_fire,
	input  reb_pkg::reb_id_t                                  alloc_id,
	input  reb_pkg::alloc_req_t                               alloc_req,
	input  logic                                              commit_fire,
	input  reb_pkg::reb_id_t                                  commit_id,
	input  logic                                              miss,
	input  reb_pkg::reg_mask_t  [reb_pkg::REB_ENTRIES-1:0]    latest_id,
	input  reb_pkg::reg_mask_t  [reb_pkg::REB_ENTRIES-1:0]    latest_id2,
	input  reb_pkg::reg_num_t                                 lookup_reg,
	output logic                                              lookup_hit,
	output reb_pkg::reb_id_t                                  lookup_id
);

	// ================================================
	// State
	// ================================================

	// Register has an in-flight writer
	logic [reb_pkg::NREGS-1:0] pending;

	// Newest writer, only meaningful while pending is set
	reb_pkg::reb_id_t [reb_pkg::NREGS-1:0] writer;

	// ================================================
	// Rebuild from the latest-writer masks
	// ================================================

	// Which entries claim each register, either destination field counts
	logic [reb_pkg::NREGS-1:0][reb_pkg::REB_ENTRIES-1:0] claim_vec;
	logic [reb_pkg::NREGS-1:0]                           claimed;
	reb_pkg::reb_id_t [reb_pkg::NREGS-1:0]               rebuilt_id;
	logic [reb_pkg::NREGS-1:0]                           multi_claim;

	always_comb begin
		for (int r = 0; r < reb_pkg::NREGS; r++) begin
			rebuilt_id[r] = '0;
			for (int e = 0; e < reb_pkg::REB_ENTRIES; e++) begin
				claim_vec[r][e] = latest_id[e][r] | latest_id2[e][r];
				if (claim_vec[r][e]) begin
					rebuilt_id[r] = reb_pkg::reb_id_t'(e);
				end
			end
			claimed[r]     = |claim_vec[r];
			multi_claim[r] = !$onehot0(claim_vec[r]);
		end
	end

	// ================================================
	// Pending bits
	// ================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= '0;
		end else if (miss) begin
			pending <= claimed;
		end else begin
			// Retiring entry drops only the registers it is still the writer of
			if (commit_fire) begin
				for (int r = 0; r < reb_pkg::NREGS; r++) begin
					if (writer[r] == commit_id) begin
						pending[r] <= 1'b0;
					end
				end
			end
			// A new writer wins over a retiring one, register 0 is never tracked
			if (alloc_fire) begin
				if (alloc_req.rt != '0) begin
					pending[alloc_req.rt] <= 1'b1;
				end
				if (alloc_req.rt2 != '0) begin
					pending[alloc_req.rt2] <= 1'b1;
				end
			end
		end
	end

	// ================================================
	// Writer ids
	// ================================================

	always_ff @(posedge clk) begin
		if (miss) begin
			for (int r = 0; r < reb_pkg::NREGS; r++) begin
				if (claimed[r]) begin
					writer[r] <= rebuilt_id[r];
				end
			end
		end else if (alloc_fire) begin
			writer[alloc_req.rt]  <= alloc_id;
			writer[alloc_req.rt2] <= alloc_id;
		end
	end

	// Lookup is combinational, the id reads 0 without a hit
	assign lookup_hit = pending[lookup_reg];
	assign lookup_id  = pending[lookup_reg] ? writer[lookup_reg] : '0;

	// The live-target logic must hand over one owner per register on a miss,
	// otherwise the rebuilt writer would depend on the loop order above
	assert property (@(posedge clk) disable iff (!arst_n)
		miss |-> (multi_claim == '0))
	else $error("more than one entry claims a register during a miss");

endmodule

// File: reb_live_target.sv
/*
 * Live-target masks for the reorder buffer.
 * Purely combinational. Reports which registers some surviving entry will
 * write, and per entry which of its targets no younger survivor overrides.
 */

`timescale 1ns/100ps

module reb_live_target (
	input  reb_pkg::reb_entry_t [reb_pkg::REB_ENTRIES-1:0]  reb,
	input  logic                [reb_pkg::REB_ENTRIES-1:0]  stomp,
	input  reb_pkg::reb_age_t   [reb_pkg::REB_ENTRIES-1:0]  ages,
	input  reb_pkg::reb_id_t                                miss_id,
	output reb_pkg::reg_mask_t                              live_target,
	output reb_pkg::reg_mask_t                              live_target2,
	output reb_pkg::reg_mask_t  [reb_pkg::REB_ENTRIES-1:0]  latest_id,
	output reb_pkg::reg_mask_t  [reb_pkg::REB_ENTRIES-1:0]  latest_id2
);

	// ================================================
	// Per-entry destination masks
	// ================================================

	// One-hot masks of each entry's rt and rt2 with register 0 removed
	reb_pkg::reg_mask_t [reb_pkg::REB_ENTRIES-1:0] dst_mask;
	reb_pkg::reg_mask_t [reb_pkg::REB_ENTRIES-1:0] dst_mask2;

	// The same masks after dropping invalid and stomped entries
	reb_pkg::reg_mask_t [reb_pkg::REB_ENTRIES-1:0] ent_live;
	reb_pkg::reg_mask_t [reb_pkg::REB_ENTRIES-1:0] ent_live2;

	// Targets of every surviving entry from this one up to the branch
	reb_pkg::reg_mask_t [reb_pkg::REB_ENTRIES-1:0] cumulative;

	always_comb begin
		for (int i = 0; i < reb_pkg::REB_ENTRIES; i++) begin
			dst_mask[i]  = (reb_pkg::reg_mask_t'(1) << reb[i].rt) & ~reb_pkg::reg_mask_t'(1);
			dst_mask2[i] = (reb_pkg::reg_mask_t'(1) << reb[i].rt2) & ~reb_pkg::reg_mask_t'(1);
			if (reb[i].v && !stomp[i]) begin
				ent_live[i]  = dst_mask[i];
				ent_live2[i] = dst_mask2[i];
			end else begin
				ent_live[i]  = '0;
				ent_live2[i] = '0;
			end
		end
	end

	// ================================================
	// Live-target masks
	// ================================================

	// A register is live while any surviving entry names it
	always_comb begin
		live_target  = '0;
		live_target2 = '0;
		for (int i = 0; i < reb_pkg::REB_ENTRIES; i++) begin
			live_target  = live_target | ent_live[i];
			live_target2 = live_target2 | ent_live2[i];
		end
	end

	// ================================================
	// Cumulative masks and latest writers
	// ================================================

	// Both destination fields feed one cumulative mask, so an rt2 write in a
	// younger entry also hides an older rt write of the same register.
	// Without that the writer map could see two claimants for one register
	always_comb begin
		for (int i = 0; i < reb_pkg::REB_ENTRIES; i++) begin
			cumulative[i] = '0;
			for (int k = 0; k < reb_pkg::REB_ENTRIES; k++) begin
				if (ages[k] >= ages[i] && ages[k] <= ages[miss_id]) begin
					cumulative[i] = cumulative[i] | ent_live[k] | ent_live2[k];
				end
			end
		end
	end

	// The slot after an entry holds the next younger one, so its cumulative
	// mask is everything younger up to the branch.
	// The branch entry is exempt because its successor may wrap to age 0
	always_comb begin
		for (int i = 0; i < reb_pkg::REB_ENTRIES; i++) begin
			if (miss_id == reb_pkg::reb_id_t'(i)) begin
				latest_id[i]  = ent_live[i];
				latest_id2[i] = ent_live2[i];
			end else begin
				latest_id[i]  = ent_live[i] & ~cumulative[(i + 1) % reb_pkg::REB_ENTRIES];
				latest_id2[i] = ent_live2[i] & ~cumulative[(i + 1) % reb_pkg::REB_ENTRIES];
			end
		end
	end

endmodule

// File: reb_queue.sv
/*
 * Reorder-buffer storage for the write tracker.
 * Allocates at the tail, retires at the head and cancels younger entries on a
 * branch miss. Also reports each entry's age relative to the head.
 */

`timescale 1ns/100ps

module reb_queue (
	input  logic                                              clk,
	input  logic                                              arst_n,
	input  logic                                              alloc,
	input  reb_pkg::alloc_req_t                               alloc_req,
	input  logic                                              commit,
	input  logic                                              miss,
	input  reb_pkg::reb_id_t                                  miss_id,
	output reb_pkg::reb_entry_t [reb_pkg::REB_ENTRIES-1:0]    reb,
	output reb_pkg::reb_age_t   [reb_pkg::REB_ENTRIES-1:0]    ages,
	output logic                [reb_pkg::REB_ENTRIES-1:0]    stomp,
	output reb_pkg::reb_id_t                                  alloc_id,
	output logic                                              alloc_fire,
	output reb_pkg::reb_id_t                                  commit_id,
	output logic                                              commit_fire,
	output logic                                              full,
	output logic                                              empty
);

	// ================================================
	// State
	// ================================================

	// One valid bit per entry
	logic [reb_pkg::REB_ENTRIES-1:0] valid;

	// Destination registers of each entry, written on allocate only
	reb_pkg::alloc_req_t [reb_pkg::REB_ENTRIES-1:0] payload;

	// Oldest entry and next free slot
	reb_pkg::reb_id_t head;
	reb_pkg::reb_id_t tail;

	// Number of valid entries, one bit wider to hold a full buffer
	logic [reb_pkg::REB_ID_W:0] count;

	// ================================================
	// Status and per-entry views
	// ================================================

	assign full  = (count == reb_pkg::REB_ENTRIES);
	assign empty = (count == '0);

	// A miss takes priority, so allocate and commit are dropped in that cycle
	assign alloc_fire  = alloc & ~full & ~miss;
	assign commit_fire = commit & ~empty & ~miss;

	assign alloc_id  = tail;
	assign commit_id = head;

	always_comb begin
		for (int i = 0; i < reb_pkg::REB_ENTRIES; i++) begin
			reb[i].v   = valid[i];
			reb[i].rt  = payload[i].rt;
			reb[i].rt2 = payload[i].rt2;
			// Age wraps with the 3-bit subtraction modulo the buffer size
			ages[i] = reb_pkg::reb_age_t'(reb_pkg::reb_id_t'(i) - head);
		end
	end

	// Every valid entry younger than the missing branch gets cancelled
	// The branch entry itself has an equal age and survives
	always_comb begin
		for (int i = 0; i < reb_pkg::REB_ENTRIES; i++) begin
			stomp[i] = miss & valid[i] & (ages[i] > ages[miss_id]);
		end
	end

	// ================================================
	// Pointer and valid-bit update
	// ================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else if (miss) begin
			// Rewind the tail to just behind the branch while the head stays put
			valid <= valid & ~stomp;
			tail  <= reb_pkg::reb_id_t'(miss_id + 1'b1);
			count <= {1'b0, ages[miss_id]} + 1'b1;
		end else begin
			if (commit_fire) begin
				valid[head] <= 1'b0;
				head        <= head + 1'b1;
			end
			// Head and tail only meet when empty or full, so these never collide
			if (alloc_fire) begin
				valid[tail] <= 1'b1;
				tail        <= tail + 1'b1;
			end
			case ({alloc_fire, commit_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Destination registers land in the tail slot on an accepted allocate
	always_ff @(posedge clk) begin
		if (alloc_fire) begin
			payload[tail] <= alloc_req;
		end
	end

	// ================================================
	// Checks
	// ================================================

	// An accepted allocate must land in a free slot and never on a live entry
	assert property (@(posedge clk) disable iff (!arst_n)
		alloc_fire |-> !valid[tail])
	else $error("allocate overwrote a live reorder-buffer entry");

	// The counter has to agree with the valid bits after every update,
	// including the rewind on a miss
	assert property (@(posedge clk) disable iff (!arst_n)
		count == $countones(valid))
	else $error("entry count out of step with valid bits");

endmodule

// File: reb_pkg.sv
/*
 * Shared sizes and types for the reorder-buffer write tracker.
 * Every design file reaches these through reb_pkg:: scoped names.
 */

package reb_pkg;

	// ================================================
	// Sizes
	// ================================================

	// Number of reorder-buffer entries
	localparam int REB_ENTRIES = 8;
	// Number of architectural registers
	localparam int NREGS = 32;

	// Bits needed for an entry index and a register number
	localparam int REB_ID_W = $clog2(REB_ENTRIES);
	localparam int REG_W = $clog2(NREGS);

	// ================================================
	// Types
	// ================================================

	// Index of one reorder-buffer entry
	typedef logic [REB_ID_W-1:0] reb_id_t;

	// Architectural register number, register 0 is never a target
	typedef logic [REG_W-1:0] reg_num_t;

	// One bit per register, bit 0 stays clear in every mask
	typedef logic [NREGS-1:0] reg_mask_t;

	// Distance of an entry from the head, 0 marks the oldest entry
	typedef logic [REB_ID_W-1:0] reb_age_t;

	// One reorder-buffer entry as seen by the live-target logic
	typedef struct packed {
		logic     v;
		reg_num_t rt;
		reg_num_t rt2;
	} reb_entry_t;

	// Destination registers that come with an allocate strobe
	typedef struct packed {
		reg_num_t rt;
		reg_num_t rt2;
	} alloc_req_t;

endpackage
